// ==== hdl/be_config.svh ====
`ifndef BE_CONFIG_SVH
`define BE_CONFIG_SVH

// Datapath and register file
`define BE_XLEN     32
`define BE_REG_NUM  32

// Reorder buffer, power of two so the slot pointers wrap on their own
`define BE_ROB_DEPTH 8

// Major opcodes handled by the issue decoder
`define BE_OPCODE_OP     7'b0110011
`define BE_OPCODE_OP_IMM 7'b0010011

`endif

// ==== hdl/be_pkg.sv ====
`include "be_config.svh"

package be_pkg;

    // Data and instruction words
    typedef logic [`BE_XLEN-1:0] xlen_t;
    typedef logic [31:0]         instr_t;

    // Architectural register index
    typedef logic [$clog2(`BE_REG_NUM)-1:0] reg_idx_t;

    // Reorder buffer slot index
    typedef logic [$clog2(`BE_ROB_DEPTH)-1:0] rob_idx_t;

    // Operations of the integer ALU
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

endpackage

// ==== hdl/be_if.sv ====
// Issue stage to ALU dispatch, one-cycle strobe
interface ex_if;
    logic             valid;
    be_pkg::alu_op_e  op;
    be_pkg::xlen_t    opa;
    be_pkg::xlen_t    opb;
    be_pkg::rob_idx_t rob_idx;

    modport issue (output valid, op, opa, opb, rob_idx);
    modport eu    (input  valid, op, opa, opb, rob_idx);
endinterface

// Issue stage to reorder buffer, allocation and operand lookup
interface rob_if;
    logic             alloc_valid;
    logic             alloc_ready;
    be_pkg::reg_idx_t alloc_rd;
    be_pkg::rob_idx_t tail_idx;
    be_pkg::rob_idx_t rs1_rob_idx;
    be_pkg::rob_idx_t rs2_rob_idx;
    logic             rs1_ready;
    logic             rs2_ready;
    be_pkg::xlen_t    rs1_value;
    be_pkg::xlen_t    rs2_value;

    modport issue (
        output alloc_valid, alloc_rd, rs1_rob_idx, rs2_rob_idx,
        input  alloc_ready, tail_idx, rs1_ready, rs1_value, rs2_ready, rs2_value
    );
    modport rob (
        input  alloc_valid, alloc_rd, rs1_rob_idx, rs2_rob_idx,
        output alloc_ready, tail_idx, rs1_ready, rs1_value, rs2_ready, rs2_value
    );
endinterface

// Issue stage to register status table
interface regstat_if;
    be_pkg::reg_idx_t rs1_idx;
    be_pkg::reg_idx_t rs2_idx;
    logic             rs1_busy;
    logic             rs2_busy;
    be_pkg::rob_idx_t rs1_rob_idx;
    be_pkg::rob_idx_t rs2_rob_idx;
    logic             upd_valid;
    be_pkg::reg_idx_t upd_rd;
    be_pkg::rob_idx_t upd_rob_idx;

    modport issue (
        output rs1_idx, rs2_idx, upd_valid, upd_rd, upd_rob_idx,
        input  rs1_busy, rs1_rob_idx, rs2_busy, rs2_rob_idx
    );
    modport rs (
        input  rs1_idx, rs2_idx, upd_valid, upd_rd, upd_rob_idx,
        output rs1_busy, rs1_rob_idx, rs2_busy, rs2_rob_idx
    );
endinterface

// Retirement broadcast, valid only on the retiring cycle
interface commit_if;
    logic             valid;
    be_pkg::reg_idx_t rd;
    be_pkg::xlen_t    value;
    be_pkg::rob_idx_t head_idx;
    logic             head_done;

    modport rob  (output valid, rd, value, head_idx, head_done);
    modport sink (input  valid, rd, value, head_idx);
endinterface

// ==== hdl/issue_ctrl.sv ====
`include "be_config.svh"

module issue_ctrl (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             instr_valid_i,
    input  be_pkg::instr_t   instr_i,
    output logic             instr_ready_o,
    output be_pkg::reg_idx_t rf_rs1_idx_o,
    output be_pkg::reg_idx_t rf_rs2_idx_o,
    input  be_pkg::xlen_t    rf_rs1_value_i,
    input  be_pkg::xlen_t    rf_rs2_value_i,
    regstat_if.issue         rs_bus,
    rob_if.issue             rob_bus,
    ex_if.issue              ex_bus
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             is_rr;
    logic             is_imm;
    logic             supported;
    be_pkg::alu_op_e  op;
    be_pkg::xlen_t    imm_sext;
    logic             rs1_ok;
    logic             rs2_ok;
    be_pkg::xlen_t    opa;
    be_pkg::xlen_t    opb;
    logic             accept;

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------
    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct7   = instr_i[31:25];
    assign imm_sext = {{(`BE_XLEN-12){instr_i[31]}}, instr_i[31:20]};

    always_comb begin
        is_rr = 1'b0;
        op    = be_pkg::ALU_ADD;
        if (opcode == `BE_OPCODE_OP) begin
            is_rr = 1'b1;
            case ({funct7, funct3})
                {7'b0000000, 3'b000}: op = be_pkg::ALU_ADD;
                {7'b0100000, 3'b000}: op = be_pkg::ALU_SUB;
                {7'b0000000, 3'b111}: op = be_pkg::ALU_AND;
                {7'b0000000, 3'b110}: op = be_pkg::ALU_OR;
                {7'b0000000, 3'b100}: op = be_pkg::ALU_XOR;
                default:              is_rr = 1'b0;
            endcase
        end
    end

    // Only ADDI among the immediate forms
    assign is_imm    = (opcode == `BE_OPCODE_OP_IMM) && (funct3 == 3'b000);
    assign supported = is_rr || is_imm;

    // ----------------------------------------------------------
    // Operand resolution
    // ----------------------------------------------------------
    assign rf_rs1_idx_o        = instr_i[19:15];
    assign rf_rs2_idx_o        = instr_i[24:20];
    assign rs_bus.rs1_idx      = instr_i[19:15];
    assign rs_bus.rs2_idx      = instr_i[24:20];
    assign rob_bus.rs1_rob_idx = rs_bus.rs1_rob_idx;
    assign rob_bus.rs2_rob_idx = rs_bus.rs2_rob_idx;

    // A renamed source must already sit in a completed ROB entry
    assign rs1_ok = !supported || !rs_bus.rs1_busy || rob_bus.rs1_ready;
    assign rs2_ok = !is_rr || !rs_bus.rs2_busy || rob_bus.rs2_ready;

    assign opa = !supported       ? '0 :
                 rs_bus.rs1_busy  ? rob_bus.rs1_value : rf_rs1_value_i;
    assign opb = is_imm           ? imm_sext :
                 !is_rr           ? '0 :
                 rs_bus.rs2_busy  ? rob_bus.rs2_value : rf_rs2_value_i;

    // Allocation and rename
    assign rob_bus.alloc_valid = instr_valid_i && rs1_ok && rs2_ok;
    assign rob_bus.alloc_rd    = supported ? instr_i[11:7] : '0;
    assign instr_ready_o       = rob_bus.alloc_ready && rs1_ok && rs2_ok;
    assign accept              = instr_valid_i && instr_ready_o;

    assign rs_bus.upd_valid   = accept;
    assign rs_bus.upd_rd      = rob_bus.alloc_rd;
    assign rs_bus.upd_rob_idx = rob_bus.tail_idx;

    // ----------------------------------------------------------
    // Registered dispatch
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_bus.valid <= 1'b0;
        end else begin
            ex_bus.valid <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            ex_bus.op      <= op;
            ex_bus.opa     <= opa;
            ex_bus.opb     <= opb;
            ex_bus.rob_idx <= rob_bus.tail_idx;
        end
    end

    // Each dispatch follows an allocation in the ROB one cycle earlier
    a_dispatch_after_alloc : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        ex_bus.valid |-> $past(rob_bus.alloc_valid && rob_bus.alloc_ready)
    );

endmodule

// ==== hdl/int_regstat.sv ====
`include "be_config.svh"

module int_regstat (
    input  logic    clk_i,
    input  logic    arst_n_i,
    regstat_if.rs   rs_bus,
    commit_if.sink  cm_bus
);

    logic [`BE_REG_NUM-1:0] busy_q;
    be_pkg::rob_idx_t       rob_idx_q [`BE_REG_NUM];

    // Lookups for both sources
    assign rs_bus.rs1_busy    = busy_q[rs_bus.rs1_idx];
    assign rs_bus.rs1_rob_idx = rob_idx_q[rs_bus.rs1_idx];
    assign rs_bus.rs2_busy    = busy_q[rs_bus.rs2_idx];
    assign rs_bus.rs2_rob_idx = rob_idx_q[rs_bus.rs2_idx];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q    <= '0;
            rob_idx_q <= '{default: '0};
        end else begin
            // Clear only if no younger producer took over the register
            if (cm_bus.valid && (rob_idx_q[cm_bus.rd] == cm_bus.head_idx)) begin
                busy_q[cm_bus.rd] <= 1'b0;
            end
            // Rename comes last so it wins on a shared edge
            if (rs_bus.upd_valid && (rs_bus.upd_rd != '0)) begin
                busy_q[rs_bus.upd_rd]    <= 1'b1;
                rob_idx_q[rs_bus.upd_rd] <= rs_bus.upd_rob_idx;
            end
        end
    end

    a_x0_never_busy : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !busy_q[0]
    );

endmodule

// ==== hdl/int_rf.sv ====
`include "be_config.svh"

module int_rf (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  be_pkg::reg_idx_t rs1_idx_i,
    input  be_pkg::reg_idx_t rs2_idx_i,
    output be_pkg::xlen_t    rs1_value_o,
    output be_pkg::xlen_t    rs2_value_o,
    commit_if.sink           cm_bus
);

    be_pkg::xlen_t regs_q [`BE_REG_NUM];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs_q <= '{default: '0};
        end else if (cm_bus.valid && (cm_bus.rd != '0)) begin
            regs_q[cm_bus.rd] <= cm_bus.value;
        end
    end

    // x0 hardwired
    assign rs1_value_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
    assign rs2_value_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

endmodule

// ==== hdl/alu_unit.sv ====
module alu_unit (
    input  logic             clk_i,
    input  logic             arst_n_i,
    ex_if.eu                 ex_bus,
    output logic             res_valid_o,
    output be_pkg::rob_idx_t res_rob_idx_o,
    output be_pkg::xlen_t    res_value_o
);

    logic             s1_valid_q;
    be_pkg::alu_op_e  s1_op_q;
    be_pkg::xlen_t    s1_opa_q;
    be_pkg::xlen_t    s1_opb_q;
    be_pkg::rob_idx_t s1_rob_idx_q;
    be_pkg::xlen_t    s1_result;

    // Valid bits of both stages
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q  <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            s1_valid_q  <= ex_bus.valid;
            res_valid_o <= s1_valid_q;
        end
    end

    // Stage two compute
    always_comb begin
        case (s1_op_q)
            be_pkg::ALU_SUB: s1_result = s1_opa_q - s1_opb_q;
            be_pkg::ALU_AND: s1_result = s1_opa_q & s1_opb_q;
            be_pkg::ALU_OR:  s1_result = s1_opa_q | s1_opb_q;
            be_pkg::ALU_XOR: s1_result = s1_opa_q ^ s1_opb_q;
            default:         s1_result = s1_opa_q + s1_opb_q;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (ex_bus.valid) begin
            s1_op_q      <= ex_bus.op;
            s1_opa_q     <= ex_bus.opa;
            s1_opb_q     <= ex_bus.opb;
            s1_rob_idx_q <= ex_bus.rob_idx;
        end
        if (s1_valid_q) begin
            res_rob_idx_o <= s1_rob_idx_q;
            res_value_o   <= s1_result;
        end
    end

endmodule

// ==== hdl/rob.sv ====
`include "be_config.svh"

module rob (
    input  logic             clk_i,
    input  logic             arst_n_i,
    rob_if.rob               rob_bus,
    input  logic             res_valid_i,
    input  be_pkg::rob_idx_t res_rob_idx_i,
    input  be_pkg::xlen_t    res_value_i,
    commit_if.rob            cm_bus,
    input  logic             commit_ready_i
);

    localparam int unsigned DEPTH = `BE_ROB_DEPTH;
    localparam int unsigned CNT_W = $clog2(DEPTH) + 1;

    logic [DEPTH-1:0] alloc_q;
    logic [DEPTH-1:0] done_q;
    be_pkg::reg_idx_t rd_q [DEPTH];
    be_pkg::xlen_t    value_q [DEPTH];
    be_pkg::rob_idx_t head_q;
    be_pkg::rob_idx_t tail_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // ----------------------------------------------------------
    // Allocation and operand lookup
    // ----------------------------------------------------------
    assign rob_bus.alloc_ready = (count_q != CNT_W'(DEPTH));
    assign rob_bus.tail_idx    = tail_q;
    assign push                = rob_bus.alloc_valid && rob_bus.alloc_ready;

    assign rob_bus.rs1_ready = done_q[rob_bus.rs1_rob_idx];
    assign rob_bus.rs1_value = value_q[rob_bus.rs1_rob_idx];
    assign rob_bus.rs2_ready = done_q[rob_bus.rs2_rob_idx];
    assign rob_bus.rs2_value = value_q[rob_bus.rs2_rob_idx];

    // ----------------------------------------------------------
    // In-order commit
    // ----------------------------------------------------------
    assign pop              = done_q[head_q] && commit_ready_i;
    assign cm_bus.head_done = done_q[head_q];
    assign cm_bus.valid     = pop;
    assign cm_bus.rd        = rd_q[head_q];
    assign cm_bus.value     = value_q[head_q];
    assign cm_bus.head_idx  = head_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alloc_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                alloc_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            if (res_valid_i) begin
                done_q[res_rob_idx_i] <= 1'b1;
            end
            if (pop) begin
                alloc_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            rd_q[tail_q] <= rob_bus.alloc_rd;
        end
        if (res_valid_i) begin
            value_q[res_rob_idx_i] <= res_value_i;
        end
    end

    // Results from the ALU land only in live entries
    a_result_hits_live_entry : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        res_valid_i |-> alloc_q[res_rob_idx_i]
    );

    a_count_in_range : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        count_q <= CNT_W'(DEPTH)
    );

endmodule

// ==== hdl/backend_top.sv ====
module backend_top (
    input  logic             clk_i,
    input  logic             arst_n_i,

    // Instruction stream
    input  logic             instr_valid_i,
    input  be_pkg::instr_t   instr_i,
    output logic             instr_ready_o,

    // Retirement
    output logic             commit_valid_o,
    output be_pkg::reg_idx_t commit_rd_o,
    output be_pkg::xlen_t    commit_value_o,
    input  logic             commit_ready_i
);

    // ----------------------------------------------------------
    // Internal buses
    // ----------------------------------------------------------
    ex_if      u_ex_if ();
    rob_if     u_rob_if ();
    regstat_if u_regstat_if ();
    commit_if  u_commit_if ();

    // Issue to register file
    be_pkg::reg_idx_t rf_rs1_idx;
    be_pkg::reg_idx_t rf_rs2_idx;
    be_pkg::xlen_t    rf_rs1_value;
    be_pkg::xlen_t    rf_rs2_value;

    // Result bus
    logic             res_valid;
    be_pkg::rob_idx_t res_rob_idx;
    be_pkg::xlen_t    res_value;

    // ----------------------------------------------------------
    // Stages
    // ----------------------------------------------------------
    issue_ctrl u_issue_ctrl (
        .clk_i          (clk_i         ),
        .arst_n_i       (arst_n_i      ),
        .instr_valid_i  (instr_valid_i ),
        .instr_i        (instr_i       ),
        .instr_ready_o  (instr_ready_o ),
        .rf_rs1_idx_o   (rf_rs1_idx    ),
        .rf_rs2_idx_o   (rf_rs2_idx    ),
        .rf_rs1_value_i (rf_rs1_value  ),
        .rf_rs2_value_i (rf_rs2_value  ),
        .rs_bus         (u_regstat_if  ),
        .rob_bus        (u_rob_if      ),
        .ex_bus         (u_ex_if       )
    );

    int_regstat u_int_regstat (
        .clk_i    (clk_i        ),
        .arst_n_i (arst_n_i     ),
        .rs_bus   (u_regstat_if ),
        .cm_bus   (u_commit_if  )
    );

    int_rf u_int_rf (
        .clk_i       (clk_i        ),
        .arst_n_i    (arst_n_i     ),
        .rs1_idx_i   (rf_rs1_idx   ),
        .rs2_idx_i   (rf_rs2_idx   ),
        .rs1_value_o (rf_rs1_value ),
        .rs2_value_o (rf_rs2_value ),
        .cm_bus      (u_commit_if  )
    );

    alu_unit u_alu_unit (
        .clk_i         (clk_i       ),
        .arst_n_i      (arst_n_i    ),
        .ex_bus        (u_ex_if     ),
        .res_valid_o   (res_valid   ),
        .res_rob_idx_o (res_rob_idx ),
        .res_value_o   (res_value   )
    );

    rob u_rob (
        .clk_i          (clk_i          ),
        .arst_n_i       (arst_n_i       ),
        .rob_bus        (u_rob_if       ),
        .res_valid_i    (res_valid      ),
        .res_rob_idx_i  (res_rob_idx    ),
        .res_value_i    (res_value      ),
        .cm_bus         (u_commit_if    ),
        .commit_ready_i (commit_ready_i )
    );

    // Head entry drives the commit port, valid ahead of the handshake
    assign commit_valid_o = u_commit_if.head_done;
    assign commit_rd_o    = u_commit_if.rd;
    assign commit_value_o = u_commit_if.value;

endmodule

// ==== dv/tb_backend.sv ====
`include "be_config.svh"

module tb_backend;

    timeunit 1ns;
    timeprecision 100ps;

    // Instruction counts per test set the watchdog budget
    localparam int N_LOAD  = 15;
    localparam int N_INDEP = 30;
    localparam int N_CHAIN = 32;
    localparam int N_STALL = 48;
    localparam int N_X0    = 6;
    localparam int N_UNSUP = 12;
    localparam int N_TOTAL = N_LOAD + N_INDEP + N_CHAIN + N_STALL + N_X0 + N_UNSUP;

    logic             clk = 1'b0;
    logic             arst_n;
    logic             instr_valid;
    be_pkg::instr_t   instr;
    logic             instr_ready;
    logic             commit_valid;
    be_pkg::reg_idx_t commit_rd;
    be_pkg::xlen_t    commit_value;
    logic             commit_ready;

    // Reference model state
    be_pkg::xlen_t    ref_regs [`BE_REG_NUM];
    be_pkg::reg_idx_t exp_rd_q [$];
    be_pkg::xlen_t    exp_val_q [$];
    be_pkg::reg_idx_t exp_rd_head;
    be_pkg::xlen_t    exp_val_head;
    int               in_flight;
    logic             accept_seen;
    logic             retire_seen;
    be_pkg::instr_t   accept_word;

    int   err_count;
    int   err_mark;
    int   pass_count;
    int   fail_count;
    logic stall_en;
    int   stall_left;
    logic full_seen;

    backend_top i_dut (
        .clk_i          (clk          ),
        .arst_n_i       (arst_n       ),
        .instr_valid_i  (instr_valid  ),
        .instr_i        (instr        ),
        .instr_ready_o  (instr_ready  ),
        .commit_valid_o (commit_valid ),
        .commit_rd_o    (commit_rd    ),
        .commit_value_o (commit_value ),
        .commit_ready_i (commit_ready )
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // Encoders and reference model
    // ------------------------------------------------------------
    function automatic be_pkg::instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input be_pkg::reg_idx_t rd,
                                             input be_pkg::reg_idx_t rs1,
                                             input be_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, `BE_OPCODE_OP};
    endfunction

    function automatic be_pkg::instr_t enc_addi(input be_pkg::reg_idx_t rd,
                                                input be_pkg::reg_idx_t rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, `BE_OPCODE_OP_IMM};
    endfunction

    // Random op with sources and destination drawn from their own ranges
    function automatic be_pkg::instr_t rand_op(input int src_lo, input int src_hi,
                                               input int dst_lo, input int dst_hi);
        be_pkg::reg_idx_t rd;
        be_pkg::reg_idx_t rs1;
        be_pkg::reg_idx_t rs2;
        rd  = $urandom_range(dst_hi, dst_lo);
        rs1 = $urandom_range(src_hi, src_lo);
        rs2 = $urandom_range(src_hi, src_lo);
        case ($urandom_range(5, 0))
            0:       return enc_r(7'h00, 3'b000, rd, rs1, rs2);
            1:       return enc_r(7'h20, 3'b000, rd, rs1, rs2);
            2:       return enc_r(7'h00, 3'b111, rd, rs1, rs2);
            3:       return enc_r(7'h00, 3'b110, rd, rs1, rs2);
            4:       return enc_r(7'h00, 3'b100, rd, rs1, rs2);
            default: return enc_addi(rd, rs1, 12'($urandom));
        endcase
    endfunction

    function automatic void model_step(input be_pkg::instr_t w);
        logic [6:0]       opc;
        logic [2:0]       f3;
        logic [6:0]       f7;
        be_pkg::reg_idx_t rd;
        be_pkg::xlen_t    a;
        be_pkg::xlen_t    b;
        be_pkg::xlen_t    res;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        rd  = w[11:7];
        a   = ref_regs[w[19:15]];
        b   = ref_regs[w[24:20]];
        res = '0;
        if (opc == `BE_OPCODE_OP && f7 == 7'h00 && f3 == 3'b000) res = a + b;
        else if (opc == `BE_OPCODE_OP && f7 == 7'h20 && f3 == 3'b000) res = a - b;
        else if (opc == `BE_OPCODE_OP && f7 == 7'h00 && f3 == 3'b111) res = a & b;
        else if (opc == `BE_OPCODE_OP && f7 == 7'h00 && f3 == 3'b110) res = a | b;
        else if (opc == `BE_OPCODE_OP && f7 == 7'h00 && f3 == 3'b100) res = a ^ b;
        else if (opc == `BE_OPCODE_OP_IMM && f3 == 3'b000) res = a + {{20{w[31]}}, w[31:20]};
        else rd = '0;
        if (rd != '0) ref_regs[rd] = res;
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(res);
    endfunction

    // ------------------------------------------------------------
    // Handshakes are sampled mid-cycle and applied on the edge
    // ------------------------------------------------------------
    always @(negedge clk) begin
        accept_seen = instr_valid && instr_ready;
        retire_seen = commit_valid && commit_ready;
        accept_word = instr;
    end

    always @(posedge clk) begin
        if (arst_n && accept_seen) model_step(accept_word);
        if (arst_n && retire_seen && exp_rd_q.size() > 0) begin
            void'(exp_rd_q.pop_front());
            void'(exp_val_q.pop_front());
        end
        in_flight = exp_rd_q.size();
        if (in_flight > 0) begin
            exp_rd_head  = exp_rd_q[0];
            exp_val_head = exp_val_q[0];
        end
        if (in_flight == `BE_ROB_DEPTH) full_seen = 1'b1;
    end

    // Random commit back-pressure stretches when enabled
    always @(posedge clk) begin
        #0.5;
        if (!stall_en) begin
            commit_ready = 1'b1;
        end else if (stall_left > 0) begin
            commit_ready = 1'b0;
            stall_left--;
        end else if ($urandom_range(3, 0) == 0) begin
            stall_left   = $urandom_range(20, 10);
            commit_ready = 1'b0;
        end else begin
            commit_ready = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Checkers
    // ------------------------------------------------------------
    a_retire_expected : assert property (@(posedge clk) disable iff (!arst_n)
        (commit_valid && commit_ready) |-> (in_flight > 0))
    else begin
        err_count++;
        $display("Retirement at %0t ns with no instruction outstanding", $time);
    end

    a_commit_rd : assert property (@(posedge clk) disable iff (!arst_n)
        (commit_valid && commit_ready && in_flight > 0) |-> (commit_rd == exp_rd_head))
    else begin
        err_count++;
        $display("** Error %0t ns: commit_rd_o expected %0d actual %0d",
                 $time, $sampled(exp_rd_head), $sampled(commit_rd));
    end

    a_commit_value : assert property (@(posedge clk) disable iff (!arst_n)
        (commit_valid && commit_ready && in_flight > 0) |-> (commit_value == exp_val_head))
    else begin
        err_count++;
        $display("** Error %0t ns: commit_value_o expected %08h actual %08h",
                 $time, $sampled(exp_val_head), $sampled(commit_value));
    end

    a_commit_hold : assert property (@(posedge clk) disable iff (!arst_n)
        (commit_valid && !commit_ready) |=>
        (commit_valid && $stable(commit_rd) && $stable(commit_value)))
    else begin
        err_count++;
        $display("Commit outputs changed at %0t ns while the commit was stalled", $time);
    end

    a_full_stalls : assert property (@(posedge clk) disable iff (!arst_n)
        (in_flight == `BE_ROB_DEPTH) |-> !instr_ready)
    else begin
        err_count++;
        $display("** Error %0t ns: instr_ready_o expected 0 actual 1", $time);
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    task automatic issue_one(input be_pkg::instr_t word);
        instr_valid = 1'b1;
        instr       = word;
        @(negedge clk);
        while (!instr_ready) @(negedge clk);
        @(posedge clk);
        #0.5;
        instr_valid = 1'b0;
    endtask

    task automatic drain_and_report(input string name);
        while (in_flight != 0) @(negedge clk);
        if (err_count == err_mark) begin
            pass_count++;
            $display("test %-14s ok", name);
        end else begin
            fail_count++;
            $display("test %-14s failed with %0d errors", name, err_count - err_mark);
        end
        err_mark = err_count;
        @(posedge clk);
        #0.5;
    endtask

    // Ends a run that stops making progress
    initial begin
        #((N_TOTAL * 40 + 10) * 4);
        $display("Watchdog expired, the backend stopped retiring instructions");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(87));
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        commit_ready = 1'b1;
        stall_en     = 1'b0;
        stall_left   = 0;
        full_seen    = 1'b0;
        in_flight    = 0;
        err_count    = 0;
        err_mark     = 0;
        pass_count   = 0;
        fail_count   = 0;
        ref_regs     = '{default: '0};
        repeat (3) @(posedge clk);
        #0.5;
        arst_n = 1'b1;

        @(negedge clk);
        assert (commit_valid === 1'b0) else begin
            err_count++;
            $display("** Error %0t ns: commit_valid_o expected 0 actual %b",
                     $time, commit_valid);
        end
        assert (instr_ready === 1'b1) else begin
            err_count++;
            $display("** Error %0t ns: instr_ready_o expected 1 actual %b",
                     $time, instr_ready);
        end
        @(posedge clk);
        #0.5;
        drain_and_report("reset");

        // Load x1..x15, then independent ops into x16..x31
        for (int i = 1; i <= N_LOAD; i++) issue_one(enc_addi(i, 0, 12'($urandom)));
        for (int i = 0; i < N_INDEP; i++) issue_one(rand_op(1, 15, 16, 31));
        drain_and_report("independent");

        // Tight RAW and WAW chains on four registers
        for (int i = 0; i < N_CHAIN; i++) issue_one(rand_op(1, 4, 1, 4));
        drain_and_report("chains");

        stall_en  = 1'b1;
        full_seen = 1'b0;
        for (int i = 0; i < N_STALL; i++) issue_one(rand_op(1, 31, 1, 31));
        while (in_flight != 0) @(negedge clk);
        stall_en = 1'b0;
        assert (full_seen) else begin
            err_count++;
            $display("The ROB never filled during the stall test");
        end
        drain_and_report("backpressure");

        issue_one(enc_addi(0, 5, 12'd123));
        issue_one(enc_r(7'h00, 3'b000, 0, 5, 6));
        issue_one(enc_r(7'h00, 3'b000, 8, 0, 0));
        issue_one(enc_addi(9, 0, 12'd77));
        issue_one(enc_r(7'h00, 3'b100, 10, 0, 5));
        issue_one(enc_r(7'h20, 3'b000, 0, 8, 9));
        drain_and_report("x0_writes");

        // Load opcode stands in for anything unsupported
        for (int i = 0; i < N_UNSUP; i++) begin
            if (i == 4 || i == 8) issue_one({25'($urandom), 7'b0000011});
            else issue_one(rand_op(1, 8, 1, 8));
        end
        drain_and_report("unsupported");

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/be_pkg.sv
hdl/be_if.sv
hdl/issue_ctrl.sv
hdl/int_regstat.sv
hdl/int_rf.sv
hdl/alu_unit.sv
hdl/rob.sv
hdl/backend_top.sv
dv/tb_backend.sv
